//--- files.f
+incdir+tests
hw/sys1_rom_pkg.sv
hw/rom_bank.sv
hw/download_decoder.sv
hw/program_rom_array.sv
hw/sys1_cart_rom.sv
tests/tb_sys1_cart_rom.sv

//--- hw/download_decoder.sv
// Download byte packer and program ROM region decoder
`default_nettype none

module download_decoder
(
	input  wire                                   clk_sys,
	input  wire                                   rst_n,
	input  wire                                   dl_active,
	input  wire                                   dl_wr,
	input  wire [sys1_rom_pkg::DL_INDEX_W-1:0]    dl_index,
	input  wire [sys1_rom_pkg::DL_ADDR_W-1:0]     dl_addr,
	input  wire [7:0]                             dl_data,
	output logic                                  wr_en,
	output sys1_rom_pkg::rom_region_e             wr_region,
	output logic [sys1_rom_pkg::BIG_BANK_AW-1:0]  wr_addr,
	output logic [sys1_rom_pkg::WORD_W-1:0]       wr_data
);
	import sys1_rom_pkg::*;

	// Upper address bits for the 32K and 64K byte region compares
	logic [$bits(ROM0_CODE)-1:0] addr_hi_32k;
	logic [$bits(ROM1_CODE)-1:0] addr_hi_64k;
	logic        byte_ok;
	logic        word_done;
	logic [7:0]  prev_byte;
	rom_region_e hit_region;

	// ##########################################################
	// Byte qualification
	// ##########################################################

	// Only file index 0 carries the program ROMs
	assign byte_ok = dl_wr && dl_active && (dl_index == '0);

	// Even byte is the high half of the word
	always_ff @(posedge clk_sys)
	begin
		if (byte_ok)
			prev_byte <= dl_data;
	end

	// ##########################################################
	// Region decode
	// ##########################################################

	assign addr_hi_32k = dl_addr[DL_ADDR_W-1 -: $bits(ROM0_CODE)];
	assign addr_hi_64k = dl_addr[DL_ADDR_W-1 -: $bits(ROM1_CODE)];

	always_comb
	begin
		hit_region = NONE;
		// Small regions first
		// 0x408000 upwards falls through to NONE
		if (addr_hi_32k == ROM0_CODE)
			hit_region = ROM0;
		else if (addr_hi_32k == SLAP_CODE)
			hit_region = SLAP;
		else
		begin
			case (addr_hi_64k)
				ROM1_CODE: hit_region = ROM1;
				ROM2_CODE: hit_region = ROM2;
				ROM5_CODE: hit_region = ROM5;
				ROM6_CODE: hit_region = ROM6;
				// ROM3 images are loaded into this slot
				ROM7_CODE: hit_region = ROM7;
				default:   hit_region = NONE;
			endcase
		end
	end

	// Odd byte inside a region closes a word
	assign word_done = byte_ok && dl_addr[0] && (hit_region != NONE);

	// ##########################################################
	// Word write
	// ##########################################################

	// One cycle strobe after the completing byte
	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
			wr_en <= 1'b0;
		else
			wr_en <= word_done;
	end

	// Target and payload of the pending write
	always_ff @(posedge clk_sys)
	begin
		if (word_done)
		begin
			wr_region <= hit_region;
			// Word address within the region
			wr_addr   <= dl_addr[BIG_BANK_AW:1];
			wr_data   <= {prev_byte, dl_data};
		end
	end

	// Strobe always names a real bank
	a_wr_region: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wr_en |-> (wr_region != NONE));

endmodule

`default_nettype wire

//--- hw/program_rom_array.sv
// Program ROM banks with CPU select decode and a two-stage read pipeline
`default_nettype none

module program_rom_array
(
	input  wire                                   clk_sys,
	input  wire                                   rst_n,
	input  wire                                   wr_en,
	input  wire sys1_rom_pkg::rom_region_e        wr_region,
	input  wire [sys1_rom_pkg::BIG_BANK_AW-1:0]   wr_addr,
	input  wire [sys1_rom_pkg::WORD_W-1:0]        wr_data,
	input  wire                                   rd_valid,
	output logic                                  rd_ready,
	input  wire [sys1_rom_pkg::CPU_ADDR_W-1:0]    rd_addr,
	input  wire [sys1_rom_pkg::ROM_SEL_W-1:0]     rd_rom_n,
	input  wire                                   rd_ma18_n,
	output logic                                  rsp_valid,
	input  wire                                   rsp_ready,
	output logic [sys1_rom_pkg::WORD_W-1:0]       rsp_data
);
	import sys1_rom_pkg::*;

	// ROM0 to SLAP in enum order
	localparam int NUM_BANKS = 7;

	logic              advance;
	rom_region_e       rd_region;
	logic              s1_valid;
	rom_region_e       s1_region;
	// Extra slot at the NONE index reads as zero
	logic [WORD_W-1:0] bank_q [NUM_BANKS+1];
	logic [WORD_W-1:0] mux_word;

	// ##########################################################
	// Banks
	// ##########################################################

	for (genvar i = 0; i < NUM_BANKS; i++)
	begin : g_bank
		localparam rom_region_e BANK_REGION = rom_region_e'(i);
		// ROM0 and SLAP are half size
		localparam int BANK_AW = (BANK_REGION == ROM0 || BANK_REGION == SLAP) ?
			SMALL_BANK_AW : BIG_BANK_AW;

		rom_bank
		#(
			.ADDR_W  (BANK_AW)
		)
		bank_i
		(
			.clk_sys (clk_sys),
			// Write steering by region
			.wr_en   (wr_en && (wr_region == BANK_REGION)),
			.wr_addr (wr_addr[BANK_AW-1:0]),
			.wr_data (wr_data),
			// Read word held during a stall
			.rd_en   (advance),
			.rd_addr (rd_addr[BANK_AW-1:0]),
			.rd_data (bank_q[i])
		);
	end

	assign bank_q[NONE] = '0;

	// ##########################################################
	// CPU select decode
	// ##########################################################

	// Priority order as on the board
	// Select 3 reaches ROM7 under both MA18n levels
	always_comb
	begin
		if (!rd_rom_n[0] && rd_ma18_n)
			rd_region = ROM0;
		else if (!rd_rom_n[1] && rd_ma18_n)
			rd_region = ROM1;
		else if (!rd_rom_n[2] && rd_ma18_n)
			rd_region = ROM2;
		else if (!rd_rom_n[3] && rd_ma18_n)
			rd_region = ROM7;
		else if (!rd_rom_n[1] && !rd_ma18_n)
			rd_region = ROM5;
		else if (!rd_rom_n[2] && !rd_ma18_n)
			rd_region = ROM6;
		else if (!rd_rom_n[3] && !rd_ma18_n)
			rd_region = ROM7;
		else if (!rd_rom_n[4])
			rd_region = SLAP;
		else
			rd_region = NONE;
	end

	// ##########################################################
	// Read pipeline
	// ##########################################################

	// Move when the output is empty or being taken
	assign advance  = !rsp_valid || rsp_ready;
	assign rd_ready = advance;

	// Bank word picked by the region that travelled with it
	assign mux_word = bank_q[s1_region];

	// Valid bits of both stages
	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			s1_valid  <= 1'b0;
			rsp_valid <= 1'b0;
		end
		else if (advance)
		begin
			s1_valid  <= rd_valid;
			rsp_valid <= s1_valid;
		end
	end

	// Stage 1 region and stage 2 word
	always_ff @(posedge clk_sys)
	begin
		if (advance)
		begin
			s1_region <= rd_region;
			rsp_data  <= mux_word;
		end
	end

	// Stalled response is held
	a_rsp_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data)));

	// No stage 1 request is lost under back-pressure
	a_s1_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(s1_valid && !advance) |=> s1_valid);

endmodule

`default_nettype wire

//--- hw/rom_bank.sv
// Simple dual-port word memory for one program ROM bank
`default_nettype none

module rom_bank
#(
	parameter int ADDR_W = 14
)
(
	input  wire                             clk_sys,
	input  wire                             wr_en,
	input  wire [ADDR_W-1:0]                wr_addr,
	input  wire [sys1_rom_pkg::WORD_W-1:0]  wr_data,
	input  wire                             rd_en,
	input  wire [ADDR_W-1:0]                rd_addr,
	output logic [sys1_rom_pkg::WORD_W-1:0] rd_data
);
	import sys1_rom_pkg::*;

	// Depth follows the address width
	localparam int DEPTH = 1 << ADDR_W;

	// Block RAM storage
	logic [WORD_W-1:0] mem [DEPTH];

	// Write port
	// Fed only by the download path
	always_ff @(posedge clk_sys)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Registered read port
	// Holds its word while the enable is low
	always_ff @(posedge clk_sys)
	begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- hw/sys1_cart_rom.sv
// Cartridge program ROM subsystem with download writer and CPU read pipeline
`default_nettype none

module sys1_cart_rom
(
	input  wire                                 clk_sys,
	input  wire                                 rst_n,
	// Host download stream
	input  wire                                 dl_active,
	input  wire                                 dl_wr,
	input  wire [sys1_rom_pkg::DL_INDEX_W-1:0]  dl_index,
	input  wire [sys1_rom_pkg::DL_ADDR_W-1:0]   dl_addr,
	input  wire [7:0]                           dl_data,
	// CPU read request
	input  wire                                 rd_valid,
	output logic                                rd_ready,
	input  wire [sys1_rom_pkg::CPU_ADDR_W-1:0]  rd_addr,
	input  wire [sys1_rom_pkg::ROM_SEL_W-1:0]   rd_rom_n,
	input  wire                                 rd_ma18_n,
	// CPU read response
	output logic                                rsp_valid,
	input  wire                                 rsp_ready,
	output logic [sys1_rom_pkg::WORD_W-1:0]     rsp_data
);
	import sys1_rom_pkg::*;

	// Word write from decoder to banks
	logic                   wr_en;
	rom_region_e            wr_region;
	logic [BIG_BANK_AW-1:0] wr_addr;
	logic [WORD_W-1:0]      wr_data;

	// Byte packing and region decode
	download_decoder download_decoder_i
	(
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_index  (dl_index),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.wr_en     (wr_en),
		.wr_region (wr_region),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	// Banks and read pipeline
	program_rom_array program_rom_array_i
	(
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.wr_region (wr_region),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_valid  (rd_valid),
		.rd_ready  (rd_ready),
		.rd_addr   (rd_addr),
		.rd_rom_n  (rd_rom_n),
		.rd_ma18_n (rd_ma18_n),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_data  (rsp_data)
	);

endmodule

`default_nettype wire

//--- hw/sys1_rom_pkg.sv
// Shared region type, widths and download address codes for the System-1 cartridge ROMs
`default_nettype none

package sys1_rom_pkg;

	// ##########################################################
	// Widths
	// ##########################################################

	// Host download byte address
	localparam int DL_ADDR_W = 25;
	// Host download file index
	localparam int DL_INDEX_W = 16;
	// CPU word address, MADEC[15:1]
	localparam int CPU_ADDR_W = 15;
	// 32K word banks
	localparam int BIG_BANK_AW = 15;
	// 16K word banks
	localparam int SMALL_BANK_AW = 14;
	localparam int WORD_W = 16;
	// Active low main ROM selects
	localparam int ROM_SEL_W = 5;

	// ##########################################################
	// Program regions
	// ##########################################################

	// Encoding doubles as the bank index in the array
	// ROM3 has no entry of its own and reads from ROM7
	typedef enum logic [2:0] {
		ROM0 = 3'd0,
		ROM1 = 3'd1,
		ROM2 = 3'd2,
		ROM5 = 3'd3,
		ROM6 = 3'd4,
		ROM7 = 3'd5,
		SLAP = 3'd6,
		NONE = 3'd7
	} rom_region_e;

	// 32K byte regions, matched on byte address [24:15]
	localparam logic [9:0] ROM0_CODE = 10'h080;
	localparam logic [9:0] SLAP_CODE = 10'h090;

	// 64K byte regions, matched on byte address [24:16]
	localparam logic [8:0] ROM1_CODE = 9'h041;
	localparam logic [8:0] ROM2_CODE = 9'h042;
	localparam logic [8:0] ROM5_CODE = 9'h045;
	localparam logic [8:0] ROM6_CODE = 9'h046;
	localparam logic [8:0] ROM7_CODE = 9'h047;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the cartridge ROM testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_sys1_cart_rom \
	-f files.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	exit 1
fi
exit 0

//--- tests/cart_rom_model.svh
// Reference model of cartridge ROM region decode, word packing and CPU read select
`ifndef CART_ROM_MODEL_SVH
`define CART_ROM_MODEL_SVH

// Written words keyed by region and word address
logic [15:0] model_mem [int];
// Last counted download byte
logic [7:0] model_prev = 8'h00;

// Region from the download byte address
function automatic rom_region_e model_region(input logic [24:0] addr);
	if (addr[24:15] == 10'h080)
		return ROM0;
	if (addr[24:15] == 10'h090)
		return SLAP;
	case (addr[24:16])
		9'h041: return ROM1;
		9'h042: return ROM2;
		9'h045: return ROM5;
		9'h046: return ROM6;
		9'h047: return ROM7;
		default: return NONE;
	endcase
endfunction

// Earlier byte is the high half
function automatic logic [15:0] pack_word(input logic [7:0] hi, input logic [7:0] lo);
	return {hi, lo};
endfunction

// Board select priority, selects active low
function automatic rom_region_e select_region(input logic [4:0] sel_n, input logic ma18_n);
	if (!sel_n[0] && ma18_n)
		return ROM0;
	if (!sel_n[1] && ma18_n)
		return ROM1;
	if (!sel_n[2] && ma18_n)
		return ROM2;
	if (!sel_n[3] && ma18_n)
		return ROM7;
	if (!sel_n[1] && !ma18_n)
		return ROM5;
	if (!sel_n[2] && !ma18_n)
		return ROM6;
	if (!sel_n[3] && !ma18_n)
		return ROM7;
	return (!sel_n[4]) ? SLAP : NONE;
endfunction

// Half size regions see 14 address bits
function automatic int model_key(input rom_region_e r, input logic [14:0] a);
	logic [14:0] wa;
	wa = (r == ROM0 || r == SLAP) ? {1'b0, a[13:0]} : a;
	return int'({14'd0, r, wa});
endfunction

// NONE reads as zero
function automatic logic [15:0] model_read(input rom_region_e r, input logic [14:0] a);
	if (r == NONE || !model_mem.exists(model_key(r, a)))
		return 16'h0000;
	return model_mem[model_key(r, a)];
endfunction

// One download byte with the counting rule
function automatic void model_byte(input logic active, input logic [15:0] index,
	input logic [24:0] addr, input logic [7:0] data);
	if (active && index == 16'd0)
	begin
		if (addr[0] && model_region(addr) != NONE)
			model_mem[model_key(model_region(addr), addr[15:1])] = pack_word(model_prev, data);
		model_prev = data;
	end
endfunction

`endif

//--- tests/tb_sys1_cart_rom.sv
// Testbench for the cartridge ROM download and read paths against a model
`default_nettype none

module tb_sys1_cart_rom;
	import sys1_rom_pkg::*;

	localparam int DRIVE_DLY = 2;
	localparam int N_WORDS = 300;
	localparam int N_IGN = 30;
	localparam int N_RD = 200;
	localparam int N_CORNER = 9;
	localparam int N_BP = 200;
	localparam int N_RATE = 20;
	// Watchdog from download bytes and reads
	localparam int N_READS = N_RD + N_IGN + N_CORNER + N_BP + N_RATE;
	localparam int LIMIT = 4 * (2 * (N_WORDS + N_IGN) + 4 * N_READS) + 200;

	logic clk_sys = 1'b0;
	logic rst_n, dl_active, dl_wr, rd_valid, rd_ready, rd_ma18_n;
	logic rsp_valid, rsp_ready;
	logic [DL_INDEX_W-1:0] dl_index;
	logic [DL_ADDR_W-1:0] dl_addr;
	logic [7:0] dl_data;
	logic [CPU_ADDR_W-1:0] rd_addr;
	logic [ROM_SEL_W-1:0] rd_rom_n;
	logic [WORD_W-1:0] rsp_data;

	string cur_test;
	int cycle = 0, checks = 0, test_errs = 0, total_errs = 0, n_tests = 0;
	int n_acc = 0, n_rsp = 0;
	logic bp_mode = 1'b0, rate_mode = 1'b0;
	// Outstanding expected words and their accept edges
	logic [WORD_W-1:0] exp_q [$];
	int acc_q [$];
	// Written download entries
	rom_region_e ent_region [$];
	logic [14:0] ent_addr [$];

	`include "cart_rom_model.svh"

	always #20 clk_sys = ~clk_sys;

	sys1_cart_rom dut_i
	(
		.clk_sys (clk_sys), .rst_n (rst_n), .dl_active (dl_active), .dl_wr (dl_wr),
		.dl_index (dl_index), .dl_addr (dl_addr), .dl_data (dl_data),
		.rd_valid (rd_valid), .rd_ready (rd_ready), .rd_addr (rd_addr),
		.rd_rom_n (rd_rom_n), .rd_ma18_n (rd_ma18_n), .rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready), .rsp_data (rsp_data)
	);

	function automatic void count_error();
		test_errs++;
		total_errs++;
	endfunction

	function automatic void check_word(input string what, input logic [15:0] exp,
		input logic [15:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			$display("** Error [%s] %s expected %h actual %h", cur_test, what, exp, act);
			count_error();
		end
	endfunction

	// ##########################################################
	// Watchdog and handshake monitor
	// ##########################################################

	always @(posedge clk_sys)
	begin
		cycle = cycle + 1;
		if (cycle > LIMIT)
		begin
			$display("Timeout after %0d cycles, the run did not complete", cycle);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// Sampled mid cycle as handshakes apply at the next edge
	always @(negedge clk_sys)
	begin
		if (rst_n && rsp_valid && rsp_ready)
		begin
			checks++;
			n_rsp++;
			assert (exp_q.size() != 0)
			else
			begin
				$display("Test %s: response seen with no request outstanding", cur_test);
				count_error();
			end
			if (exp_q.size() != 0)
			begin
				check_word("read data", exp_q.pop_front(), rsp_data);
				if (rate_mode)
					check_word("latency", 16'd2, 16'(cycle + 1 - acc_q[0]));
				void'(acc_q.pop_front());
			end
		end
		if (rst_n && rate_mode)
			check_word("rd_ready", 16'd1, {15'd0, rd_ready});
		// Expected word fixed at acceptance
		if (rst_n && rd_valid && rd_ready)
		begin
			exp_q.push_back(model_read(select_region(rd_rom_n, rd_ma18_n), rd_addr));
			acc_q.push_back(cycle + 1);
			n_acc++;
		end
	end

	// ##########################################################
	// Stimulus tasks
	// ##########################################################

	// Next drive point with random rsp_ready under back-pressure
	task automatic step();
		@(posedge clk_sys);
		#DRIVE_DLY;
		if (bp_mode)
			rsp_ready = ($urandom_range(0, 1) == 32'd1);
	endtask

	task automatic send_word(input logic [15:0] index, input logic active,
		input logic [24:0] addr, input logic [15:0] word);
		dl_index = index;
		dl_active = active;
		for (int b = 0; b < 2; b++)
		begin
			dl_wr = 1'b1;
			dl_addr = addr | 25'(b);
			dl_data = (b == 0) ? word[15:8] : word[7:0];
			model_byte(active, index, dl_addr, dl_data);
			step();
			dl_wr = 1'b0;
		end
	endtask

	// Holds the request until rd_ready takes it
	task automatic read_req(input logic [4:0] sel_n, input logic ma18_n, input logic [14:0] addr);
		logic taken;
		rd_valid = 1'b1;
		rd_rom_n = sel_n;
		rd_ma18_n = ma18_n;
		rd_addr = addr;
		taken = 1'b0;
		while (!taken)
		begin
			@(negedge clk_sys);
			taken = rd_ready;
			step();
		end
		rd_valid = 1'b0;
	endtask

	// Select pattern that reaches one region
	task automatic read_region(input rom_region_e r, input logic [14:0] addr);
		logic ma;
		ma = ($urandom_range(0, 1) == 32'd1);
		case (r)
			ROM0: read_req(5'b11110, 1'b1, addr);
			ROM1: read_req(5'b11101, 1'b1, addr);
			ROM2: read_req(5'b11011, 1'b1, addr);
			ROM5: read_req(5'b11101, 1'b0, addr);
			ROM6: read_req(5'b11011, 1'b0, addr);
			ROM7: read_req(5'b10111, ma, addr);
			default: read_req(5'b01111, ma, addr);
		endcase
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			step();
	endtask

	function automatic logic [24:0] region_base(input rom_region_e r);
		case (r)
			ROM0: return 25'h040_0000;
			ROM1: return 25'h041_0000;
			ROM2: return 25'h042_0000;
			ROM5: return 25'h045_0000;
			ROM6: return 25'h046_0000;
			ROM7: return 25'h047_0000;
			default: return 25'h048_0000;
		endcase
	endfunction

	task automatic end_test();
		$display("Test %s %s, %0d errors", cur_test, (test_errs == 0) ? "passed" : "failed",
			test_errs);
		n_tests++;
		test_errs = 0;
	endtask

	// ##########################################################
	// Test sequence
	// ##########################################################

	initial
	begin
		int k;
		logic [31:0] rnd;
		logic [14:0] waddr;
		logic [24:0] addr;
		rom_region_e r;
		int hit_q [$];
		void'($urandom(32'h1cfd_a452));
		rst_n = 1'b0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_index = '0;
		dl_addr = '0;
		dl_data = '0;
		rd_valid = 1'b0;
		rd_addr = '0;
		rd_rom_n = '1;
		rd_ma18_n = 1'b1;
		rsp_ready = 1'b1;
		repeat (4) @(posedge clk_sys);
		#DRIVE_DLY;
		rst_n = 1'b1;

		cur_test = "reset";
		@(negedge clk_sys);
		check_word("rsp_valid", 16'd0, {15'd0, rsp_valid});
		check_word("rd_ready", 16'd1, {15'd0, rd_ready});
		step();
		end_test();

		// Entry i lands in region i mod 7
		cur_test = "download";
		for (int i = 0; i < N_WORDS; i++)
		begin
			r = rom_region_e'(i % 7);
			rnd = $urandom();
			waddr = (r == ROM0 || r == SLAP) ? {1'b0, rnd[13:0]} : rnd[14:0];
			send_word(16'd0, 1'b1, region_base(r) | {9'd0, waddr, 1'b0}, rnd[31:16]);
			ent_region.push_back(r);
			ent_addr.push_back(waddr);
			if (rnd[15])
				step();
		end
		repeat (2) step();
		for (int i = 0; i < N_RD; i++)
		begin
			k = $urandom_range(0, N_WORDS - 1);
			read_region(ent_region[k], ent_addr[k]);
		end
		drain();
		end_test();

		// Nonzero index, inactive download, unmapped window
		cur_test = "ignored";
		for (int j = 0; j < N_IGN; j++)
		begin
			k = $urandom_range(0, N_WORDS - 1);
			r = ent_region[k];
			addr = region_base(r) | {9'd0, ent_addr[k], 1'b0};
			rnd = $urandom();
			case (j % 3)
				0: send_word({rnd[15:1], 1'b1}, 1'b1, addr, rnd[31:16]);
				1: send_word(16'd0, 1'b0, addr, rnd[31:16]);
				default: send_word(16'd0, 1'b1, (r == ROM0 || r == SLAP) ?
					(addr | 25'h000_8000) : {9'h043, addr[15:0]}, rnd[31:16]);
			endcase
			hit_q.push_back(k);
		end
		repeat (2) step();
		foreach (hit_q[j])
			read_region(ent_region[hit_q[j]], ent_addr[hit_q[j]]);
		drain();
		end_test();

		// Entries 0, 5 and 6 are ROM0, ROM7 and SLAP
		cur_test = "select";
		read_req(5'b11111, 1'b1, rnd[14:0]);
		read_req(5'b11111, 1'b0, rnd[14:0]);
		read_req(5'b11110, 1'b0, rnd[14:0]);
		read_req(5'b10111, 1'b1, ent_addr[5]);
		read_req(5'b10111, 1'b0, ent_addr[5]);
		read_req(5'b11110, 1'b1, ent_addr[0] | 15'h4000);
		read_req(5'b11110, 1'b1, ent_addr[0]);
		read_req(5'b01111, 1'b0, ent_addr[6] | 15'h4000);
		read_req(5'b01111, 1'b0, ent_addr[6]);
		drain();
		end_test();

		cur_test = "backpressure";
		n_acc = 0;
		n_rsp = 0;
		bp_mode = 1'b1;
		for (int i = 0; i < N_BP; i++)
		begin
			repeat ($urandom_range(0, 2)) step();
			k = $urandom_range(0, N_WORDS - 1);
			read_region(ent_region[k], ent_addr[k]);
		end
		drain();
		bp_mode = 1'b0;
		rsp_ready = 1'b1;
		// Late repeated responses still land in the count
		repeat (2) step();
		checks++;
		assert (n_rsp == n_acc)
		else
		begin
			$display("Test %s: %0d requests accepted but %0d responses seen", cur_test,
				n_acc, n_rsp);
			count_error();
		end
		end_test();

		// Back to back requests with rsp_ready high
		cur_test = "rate";
		rate_mode = 1'b1;
		for (int i = 0; i < N_RATE; i++)
			read_region(ent_region[i], ent_addr[i]);
		drain();
		rate_mode = 1'b0;
		end_test();

		$display("Tests %0d, checks %0d, errors %0d", n_tests, checks, total_errs);
		if (total_errs == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
